// File: logic/nfc_pkg.sv
// Shared MFRC522 register map, ISO14443A codes and bus types
// Covers cascade level 1 only, so 4-byte UIDs

package nfc_pkg;

  typedef logic [5:0]  nfc_addr_t;
  typedef logic [7:0]  nfc_byte_t;
  typedef logic [31:0] card_uid_t;   // First received byte in 31:24

  // MFRC522 registers
  localparam nfc_addr_t reg_command    = 6'h01;
  localparam nfc_addr_t reg_comirq     = 6'h04;
  localparam nfc_addr_t reg_fifodata   = 6'h09;
  localparam nfc_addr_t reg_fifolevel  = 6'h0A;
  localparam nfc_addr_t reg_bitframing = 6'h0D;
  localparam nfc_addr_t reg_txmode     = 6'h12;
  localparam nfc_addr_t reg_rxmode     = 6'h13;

  // Register values
  localparam nfc_byte_t pcd_transceive = 8'h0C;
  localparam nfc_byte_t irq_clear_all  = 8'h7F;
  localparam nfc_byte_t fifo_flush     = 8'h80;   // FlushBuffer bit
  localparam nfc_byte_t crc_enable     = 8'h80;
  localparam nfc_byte_t crc_disable    = 8'h00;
  localparam nfc_byte_t framing_short  = 8'h87;   // StartSend, 7 bits
  localparam nfc_byte_t framing_full   = 8'h80;   // StartSend, 8 bits

  // ISO14443A codes
  localparam nfc_byte_t cmd_reqa     = 8'h26;
  localparam nfc_byte_t cmd_sel_cl1  = 8'h93;
  localparam nfc_byte_t nvb_anticoll = 8'h20;
  localparam nfc_byte_t nvb_select   = 8'h70;
  localparam logic [15:0] atqa_mifare = 16'h0004;

  localparam int rx_irq_bit      = 5;
  localparam int sak_cascade_bit = 2;

  // Error codes
  localparam nfc_byte_t err_cascade = 8'h01;
  localparam nfc_byte_t err_no_card = 8'hFF;

  typedef enum logic [1:0] {
    prot_reqa,
    prot_anticoll,
    prot_select
  } prot_step_t;

  typedef struct packed {
    logic      write;
    nfc_addr_t addr;
    nfc_byte_t wdata;
  } nfc_cmd_t;

  typedef struct packed {
    logic [3:0] tx_length;   // Bytes written to the FIFO
    nfc_byte_t  framing;     // BitFramingReg value
    logic       crc_en;
  } frame_cfg_t;

endpackage

// File: logic/nfc_frame_builder.sv
`timescale 1ns/10ps
// Transmit frame per protocol step, SELECT carries its own BCC
// CRC bytes come from the reader, not from here

module nfc_frame_builder (
  input  nfc_pkg::prot_step_t   step,
  input  logic [3:0]            tx_index,
  input  nfc_pkg::card_uid_t    uid,
  output nfc_pkg::frame_cfg_t   frame_cfg,
  output nfc_pkg::nfc_byte_t    tx_byte
);

  nfc_pkg::nfc_byte_t bcc;

  assign bcc = uid[31:24] ^ uid[23:16] ^ uid[15:8] ^ uid[7:0];

  always_comb begin
    frame_cfg.tx_length = 4'd1;   // REQA, short frame
    frame_cfg.framing   = nfc_pkg::framing_short;
    frame_cfg.crc_en    = 1'b0;
    tx_byte             = nfc_pkg::cmd_reqa;
    case (step)
      nfc_pkg::prot_anticoll: begin
        frame_cfg.tx_length = 4'd2;
        frame_cfg.framing   = nfc_pkg::framing_full;
        tx_byte = (tx_index == 4'd0) ? nfc_pkg::cmd_sel_cl1 : nfc_pkg::nvb_anticoll;
      end
      nfc_pkg::prot_select: begin
        frame_cfg.tx_length = 4'd7;
        frame_cfg.framing   = nfc_pkg::framing_full;
        frame_cfg.crc_en    = 1'b1;
        case (tx_index)
          4'd0:    tx_byte = nfc_pkg::cmd_sel_cl1;
          4'd1:    tx_byte = nfc_pkg::nvb_select;
          4'd2:    tx_byte = uid[31:24];   // Received order
          4'd3:    tx_byte = uid[23:16];
          4'd4:    tx_byte = uid[15:8];
          4'd5:    tx_byte = uid[7:0];
          default: tx_byte = bcc;
        endcase
      end
      default: ;
    endcase
  end

endmodule

// File: logic/nfc_response_capture.sv
`timescale 1ns/10ps
// Sorts received FIFO bytes into ATQA, UID or SAK by protocol step
// Anticollision BCC (byte 4) is not stored

module nfc_response_capture (
  input  logic                  clk,
  input  logic                  rst_n,
  input  nfc_pkg::prot_step_t   step,
  input  logic                  rx_valid,
  input  logic [3:0]            rx_index,
  input  nfc_pkg::nfc_byte_t    rx_data,
  output logic [15:0]           atqa,
  output nfc_pkg::card_uid_t    uid,
  output nfc_pkg::nfc_byte_t    sak
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      atqa <= 16'h0000;
      uid  <= 32'h0000_0000;
      sak  <= 8'h00;
    end else if (rx_valid) begin
      case (step)
        nfc_pkg::prot_reqa: begin
          if (rx_index == 4'd0) atqa[7:0]  <= rx_data;   // Low byte first
          if (rx_index == 4'd1) atqa[15:8] <= rx_data;
        end
        nfc_pkg::prot_anticoll: begin
          // Byte 0 lands in 31:24
          if (rx_index < 4'd4) uid[{~rx_index[1:0], 3'b000} +: 8] <= rx_data;
        end
        default: begin
          if (rx_index == 4'd0) sak <= rx_data;
        end
      endcase
    end
  end

endmodule

// File: logic/nfc_transceive_seq.sv
`timescale 1ns/10ps
// One MFRC522 transceive per xfer_start, response capped at 15 bytes
// RxIRq is polled without a timeout, a silent reader stalls the sequence

module nfc_transceive_seq (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  xfer_start,
  output logic                  xfer_done,
  input  nfc_pkg::frame_cfg_t   frame_cfg,
  output logic [3:0]            tx_index,
  input  nfc_pkg::nfc_byte_t    tx_byte,
  output logic                  nfc_cmd_valid,
  input  logic                  nfc_cmd_ready,
  output nfc_pkg::nfc_cmd_t     nfc_cmd,
  input  nfc_pkg::nfc_byte_t    nfc_cmd_rdata,
  input  logic                  nfc_cmd_done,
  output logic                  rx_valid,
  output logic [3:0]            rx_index,
  output nfc_pkg::nfc_byte_t    rx_data
);

  typedef enum logic [3:0] {
    st_idle, st_clr_irq, st_flush, st_tx_mode,
    st_rx_mode, st_fifo_wr, st_transceive, st_framing,
    st_poll, st_level, st_read
  } seq_state_t;

  seq_state_t         state;
  logic               pending;      // Command out, waiting for done
  logic               cmd_end;
  logic               last_rx;
  logic [3:0]         rx_count;
  logic [6:0]         fifo_level;
  nfc_pkg::nfc_byte_t crc_mode;

  assign cmd_end       = pending && nfc_cmd_done;
  assign nfc_cmd_valid = (state != st_idle) && !pending && nfc_cmd_ready;
  assign fifo_level    = nfc_cmd_rdata[6:0];
  assign last_rx       = (rx_index == rx_count - 4'd1);
  assign crc_mode      = frame_cfg.crc_en ? nfc_pkg::crc_enable : nfc_pkg::crc_disable;

  assign rx_valid  = cmd_end && (state == st_read);
  assign rx_data   = nfc_cmd_rdata;
  assign xfer_done = cmd_end && (((state == st_read) && last_rx) ||
                                 ((state == st_level) && (fifo_level == 7'd0)));

  // Fields only depend on state and indices, so they hold until done
  always_comb begin
    nfc_cmd.write = 1'b1;
    nfc_cmd.addr  = nfc_pkg::reg_comirq;
    nfc_cmd.wdata = nfc_pkg::irq_clear_all;
    case (state)
      st_flush: begin
        nfc_cmd.addr  = nfc_pkg::reg_fifolevel;
        nfc_cmd.wdata = nfc_pkg::fifo_flush;
      end
      st_tx_mode: begin
        nfc_cmd.addr  = nfc_pkg::reg_txmode;
        nfc_cmd.wdata = crc_mode;
      end
      st_rx_mode: begin
        nfc_cmd.addr  = nfc_pkg::reg_rxmode;
        nfc_cmd.wdata = crc_mode;
      end
      st_fifo_wr: begin
        nfc_cmd.addr  = nfc_pkg::reg_fifodata;
        nfc_cmd.wdata = tx_byte;
      end
      st_transceive: begin
        nfc_cmd.addr  = nfc_pkg::reg_command;
        nfc_cmd.wdata = nfc_pkg::pcd_transceive;
      end
      st_framing: begin
        nfc_cmd.addr  = nfc_pkg::reg_bitframing;
        nfc_cmd.wdata = frame_cfg.framing;
      end
      st_poll, st_level, st_read: begin
        nfc_cmd.write = 1'b0;
        nfc_cmd.wdata = 8'h00;
        if (state == st_level) nfc_cmd.addr = nfc_pkg::reg_fifolevel;
        if (state == st_read)  nfc_cmd.addr = nfc_pkg::reg_fifodata;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      pending  <= 1'b0;
      tx_index <= 4'd0;
      rx_index <= 4'd0;
      rx_count <= 4'd0;
    end else begin
      if (nfc_cmd_valid) pending <= 1'b1;
      else if (cmd_end)  pending <= 1'b0;
      case (state)
        st_idle: if (xfer_start) begin
          tx_index <= 4'd0;
          state    <= st_clr_irq;
        end
        st_clr_irq:    if (cmd_end) state <= st_flush;
        st_flush:      if (cmd_end) state <= st_tx_mode;
        st_tx_mode:    if (cmd_end) state <= st_rx_mode;
        st_rx_mode:    if (cmd_end) state <= st_fifo_wr;
        st_fifo_wr: if (cmd_end) begin
          if (tx_index == frame_cfg.tx_length - 4'd1) state <= st_transceive;
          else tx_index <= tx_index + 4'd1;
        end
        st_transceive: if (cmd_end) state <= st_framing;
        st_framing:    if (cmd_end) state <= st_poll;
        st_poll: if (cmd_end && nfc_cmd_rdata[nfc_pkg::rx_irq_bit]) state <= st_level;
        st_level: if (cmd_end) begin
          rx_index <= 4'd0;
          rx_count <= (fifo_level > 7'd15) ? 4'd15 : fifo_level[3:0];
          state    <= (fifo_level == 7'd0) ? st_idle : st_read;
        end
        st_read: if (cmd_end) begin
          if (last_rx) state <= st_idle;
          else rx_index <= rx_index + 4'd1;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: logic/nfc_protocol_ctrl.sv
`timescale 1ns/10ps
// REQA, anticollision CL1 and SELECT CL1 in order, one transceive each
// A SAK asking for cascade level 2 ends the detection with err_cascade

module nfc_protocol_ctrl #(
  parameter int max_reqa_tries = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  detect_start,
  output logic                  idle,
  output nfc_pkg::prot_step_t   step,
  output logic                  xfer_start,
  input  logic                  xfer_done,
  input  logic [15:0]           atqa,
  input  nfc_pkg::card_uid_t    uid,
  input  nfc_pkg::nfc_byte_t    sak,
  output logic                  card_detected,
  output logic                  card_ready,
  output logic                  start_auth,
  output logic                  detection_error,
  output nfc_pkg::card_uid_t    card_uid,
  output nfc_pkg::nfc_byte_t    error_code
);

  localparam int try_w = $clog2(max_reqa_tries + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_xfer,    // Transceive running
    st_check    // Response evaluated here
  } ctrl_state_t;

  ctrl_state_t      state;
  logic [try_w-1:0] bad_atqa_cnt;
  logic             select_ok;

  assign idle      = (state == st_idle);
  assign select_ok = (state == st_check) && (step == nfc_pkg::prot_select) &&
                     !sak[nfc_pkg::sak_cascade_bit];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= st_idle;
      step            <= nfc_pkg::prot_reqa;
      xfer_start      <= 1'b0;
      bad_atqa_cnt    <= '0;
      card_detected   <= 1'b0;
      card_ready      <= 1'b0;
      start_auth      <= 1'b0;
      detection_error <= 1'b0;
      error_code      <= 8'h00;
    end else begin
      xfer_start <= 1'b0;
      start_auth <= 1'b0;
      case (state)
        st_idle: if (detect_start) begin
          card_detected   <= 1'b0;
          card_ready      <= 1'b0;
          detection_error <= 1'b0;
          error_code      <= 8'h00;
          bad_atqa_cnt    <= '0;
          step            <= nfc_pkg::prot_reqa;
          xfer_start      <= 1'b1;
          state           <= st_xfer;
        end
        st_xfer: if (xfer_done) state <= st_check;
        st_check: begin
          state <= st_xfer;   // Next exchange unless finished below
          case (step)
            nfc_pkg::prot_reqa: begin
              if (atqa == nfc_pkg::atqa_mifare) begin
                card_detected <= 1'b1;
                step          <= nfc_pkg::prot_anticoll;
                xfer_start    <= 1'b1;
              end else if (bad_atqa_cnt == try_w'(max_reqa_tries - 1)) begin
                detection_error <= 1'b1;   // Every attempt gave a wrong ATQA
                error_code      <= nfc_pkg::err_no_card;
                state           <= st_idle;
              end else begin
                bad_atqa_cnt <= bad_atqa_cnt + 1'b1;
                xfer_start   <= 1'b1;
              end
            end
            nfc_pkg::prot_anticoll: begin
              step       <= nfc_pkg::prot_select;
              xfer_start <= 1'b1;
            end
            default: begin
              state <= st_idle;
              if (select_ok) begin
                card_ready <= 1'b1;
                start_auth <= 1'b1;
              end else begin
                detection_error <= 1'b1;
                error_code      <= nfc_pkg::err_cascade;
              end
            end
          endcase
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (select_ok) card_uid <= uid;
  end

endmodule

// File: logic/nfc_card_detector.sv
`timescale 1ns/10ps
// ISO14443A card detection over the MFRC522 register bus, cascade level 1 only
// IRQ rising edges are ignored while a detection runs

module nfc_card_detector #(
  parameter int max_reqa_tries = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  nfc_irq,
  output logic                  nfc_cmd_valid,
  input  logic                  nfc_cmd_ready,
  output nfc_pkg::nfc_cmd_t     nfc_cmd,
  input  nfc_pkg::nfc_byte_t    nfc_cmd_rdata,
  input  logic                  nfc_cmd_done,
  output logic                  card_detected,
  output logic                  card_ready,
  output logic                  start_auth,
  output logic                  detection_error,
  output nfc_pkg::card_uid_t    card_uid,
  output nfc_pkg::nfc_byte_t    error_code
);

  logic                  irq_prev;
  logic                  detect_start;
  logic                  idle;
  logic                  xfer_start;
  logic                  xfer_done;
  logic                  rx_valid;
  logic [3:0]            tx_index;
  logic [3:0]            rx_index;
  logic [15:0]           atqa;
  nfc_pkg::prot_step_t   step;
  nfc_pkg::frame_cfg_t   frame_cfg;
  nfc_pkg::nfc_byte_t    tx_byte;
  nfc_pkg::nfc_byte_t    rx_data;
  nfc_pkg::nfc_byte_t    sak;
  nfc_pkg::card_uid_t    uid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_prev <= 1'b0;
    end else begin
      irq_prev <= nfc_irq;
    end
  end

  assign detect_start = nfc_irq && !irq_prev && idle;   // Rising edge, idle only

  nfc_protocol_ctrl #(
    .max_reqa_tries(max_reqa_tries)
  ) u_ctrl (
    .clk(clk), .rst_n(rst_n), .detect_start(detect_start), .idle(idle),
    .step(step), .xfer_start(xfer_start), .xfer_done(xfer_done),
    .atqa(atqa), .uid(uid), .sak(sak),
    .card_detected(card_detected), .card_ready(card_ready), .start_auth(start_auth),
    .detection_error(detection_error), .card_uid(card_uid), .error_code(error_code)
  );

  nfc_transceive_seq u_seq (
    .clk(clk), .rst_n(rst_n), .xfer_start(xfer_start), .xfer_done(xfer_done),
    .frame_cfg(frame_cfg), .tx_index(tx_index), .tx_byte(tx_byte),
    .nfc_cmd_valid(nfc_cmd_valid), .nfc_cmd_ready(nfc_cmd_ready), .nfc_cmd(nfc_cmd),
    .nfc_cmd_rdata(nfc_cmd_rdata), .nfc_cmd_done(nfc_cmd_done),
    .rx_valid(rx_valid), .rx_index(rx_index), .rx_data(rx_data)
  );

  nfc_frame_builder u_frame (
    .step(step), .tx_index(tx_index), .uid(uid), .frame_cfg(frame_cfg), .tx_byte(tx_byte)
  );

  nfc_response_capture u_capture (
    .clk(clk), .rst_n(rst_n), .step(step), .rx_valid(rx_valid), .rx_index(rx_index),
    .rx_data(rx_data), .atqa(atqa), .uid(uid), .sak(sak)
  );

endmodule

// File: verif/mfrc522_model.sv
`timescale 1ns/10ps
// Behavioral MFRC522 with one ISO14443A card in the field, no CRC or RF timing
// Frames are decoded from the FIFO contents when Transceive is written

module mfrc522_model #(
  parameter logic [31:0] seed = 32'h0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               nfc_cmd_valid,
  output logic               nfc_cmd_ready,
  input  nfc_pkg::nfc_cmd_t  nfc_cmd,
  output nfc_pkg::nfc_byte_t nfc_cmd_rdata,
  output logic               nfc_cmd_done,
  input  logic               case_load,
  input  logic [15:0]        case_atqa,
  input  logic [7:0]         case_bad,
  input  logic [31:0]        case_uid,
  input  logic [7:0]         case_sak,
  output logic [7:0]         reqa_frames,
  output logic [55:0]        select_frame
);

  logic [7:0] fifo_buf [0:15];
  logic [7:0] resp [0:4];
  logic [7:0] answer;
  logic       seeded = 1'b0;
  int         fifo_len = 0;
  int         resp_len = 0;
  int         rd_ptr = 0;
  int         poll_cnt = 0;
  int         bad_left = 0;
  int         accepted = 0;   // Commands taken at posedge
  int         served = 0;     // Commands answered with done
  int         done_wait = 0;
  int         ready_wait = 0;

  initial begin
    nfc_cmd_ready = 1'b0;
    nfc_cmd_done  = 1'b0;
    nfc_cmd_rdata = 8'h00;
    reqa_frames   = 8'h00;
    select_frame  = '0;
  end

  // Card reply to the frame now sitting in the FIFO
  task automatic start_reply();
    rd_ptr   = 0;
    poll_cnt = 0;
    resp_len = 0;
    if (fifo_len == 1 && fifo_buf[0] == 8'h26) begin
      reqa_frames = reqa_frames + 8'd1;
      resp_len = 2;
      {resp[1], resp[0]} = (bad_left > 0) ? case_atqa : 16'h0004;   // Low byte first
      if (bad_left > 0) bad_left = bad_left - 1;
    end else if (fifo_len == 2 && fifo_buf[0] == 8'h93 && fifo_buf[1] == 8'h20) begin
      resp_len = 5;
      {resp[0], resp[1], resp[2], resp[3]} = case_uid;
      resp[4] = case_uid[31:24] ^ case_uid[23:16] ^ case_uid[15:8] ^ case_uid[7:0];
    end else if (fifo_len == 7 && fifo_buf[0] == 8'h93 && fifo_buf[1] == 8'h70) begin
      resp_len = 1;
      resp[0]  = case_sak;
      select_frame = {fifo_buf[0], fifo_buf[1], fifo_buf[2], fifo_buf[3],
                      fifo_buf[4], fifo_buf[5], fifo_buf[6]};
    end
  endtask

  task automatic handle_command(input nfc_pkg::nfc_cmd_t cmd);
    answer = 8'h00;
    if (cmd.write) begin
      if (cmd.addr == nfc_pkg::reg_fifodata && fifo_len < 16) begin
        fifo_buf[fifo_len] = cmd.wdata;
        fifo_len = fifo_len + 1;
      end
      if (cmd.addr == nfc_pkg::reg_fifolevel && cmd.wdata[7]) fifo_len = 0;   // Flush
      if (cmd.addr == nfc_pkg::reg_command && cmd.wdata == 8'h0C) start_reply();
    end else begin
      case (cmd.addr)
        nfc_pkg::reg_comirq: begin
          poll_cnt = poll_cnt + 1;
          answer   = (poll_cnt >= 3) ? 8'h20 : 8'h00;   // RxIRq on third poll
        end
        nfc_pkg::reg_fifolevel: answer = resp_len[7:0];
        nfc_pkg::reg_fifodata: begin
          if (rd_ptr < resp_len) answer = resp[rd_ptr];
          rd_ptr = rd_ptr + 1;
        end
        default: answer = 8'h00;
      endcase
    end
  endtask

  always @(posedge clk) begin
    if (case_load) begin
      bad_left     = case_bad;
      reqa_frames  = 8'h00;
      select_frame = '0;
    end
    if (rst_n && nfc_cmd_valid) begin
      handle_command(nfc_cmd);
      accepted = accepted + 1;
    end
  end

  // Handshake timing, all outputs change on the falling edge
  always @(negedge clk or negedge rst_n) begin
    if (!seeded) begin
      void'($urandom(seed));
      seeded = 1'b1;
    end
    if (!rst_n) begin
      nfc_cmd_ready <= 1'b0;
      nfc_cmd_done  <= 1'b0;
      served     = accepted;
      done_wait  = $urandom_range(3, 0);
      ready_wait = 0;
    end else begin
      nfc_cmd_done <= 1'b0;
      if (served != accepted) begin
        nfc_cmd_ready <= 1'b0;
        if (done_wait == 0) begin
          nfc_cmd_done  <= 1'b1;
          nfc_cmd_rdata <= answer;
          served     = served + 1;
          done_wait  = $urandom_range(3, 0);
          ready_wait = $urandom_range(3, 0);
        end else begin
          done_wait = done_wait - 1;
        end
      end else if (ready_wait == 0) begin
        nfc_cmd_ready <= 1'b1;
      end else begin
        ready_wait = ready_wait - 1;
      end
    end
  end

endmodule

// File: verif/tb_nfc_card_detector.sv
`timescale 1ns/10ps
// Card cases come from verif/detect_cases.txt when run from the project root
// Assumes the detector's REQA limit of 4 attempts

module tb_nfc_card_detector;

  localparam int reqa_limit     = 4;
  localparam int timeout_cycles = 20000;
  localparam int max_cases      = 16;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               nfc_irq;
  logic               nfc_cmd_valid;
  logic               nfc_cmd_ready;
  nfc_pkg::nfc_cmd_t  nfc_cmd;
  nfc_pkg::nfc_byte_t nfc_cmd_rdata;
  logic               nfc_cmd_done;
  logic               card_detected;
  logic               card_ready;
  logic               start_auth;
  logic               detection_error;
  nfc_pkg::card_uid_t card_uid;
  nfc_pkg::nfc_byte_t error_code;
  logic               case_load;
  logic [15:0]        case_atqa;
  logic [7:0]         case_bad;
  logic [31:0]        case_uid;
  logic [7:0]         case_sak;
  logic [7:0]         reqa_frames;
  logic [55:0]        select_frame;
  logic [31:0]        case_mem [0:4*max_cases-1];   // atqa, bad count, uid, sak
  logic               valid_prev = 1'b0;
  logic               timed_out = 1'b0;
  int                 case_errors = 0;
  int                 auth_count = 0;
  int                 passed = 0;
  int                 failed = 0;

  always #4 clk = ~clk;

  nfc_card_detector #(
    .max_reqa_tries(reqa_limit)
  ) UUT (
    .clk(clk), .rst_n(rst_n), .nfc_irq(nfc_irq),
    .nfc_cmd_valid(nfc_cmd_valid), .nfc_cmd_ready(nfc_cmd_ready), .nfc_cmd(nfc_cmd),
    .nfc_cmd_rdata(nfc_cmd_rdata), .nfc_cmd_done(nfc_cmd_done),
    .card_detected(card_detected), .card_ready(card_ready), .start_auth(start_auth),
    .detection_error(detection_error), .card_uid(card_uid), .error_code(error_code)
  );

  mfrc522_model #(
    .seed(32'h28e6b362)
  ) mfrc522_model (
    .clk(clk), .rst_n(rst_n), .nfc_cmd_valid(nfc_cmd_valid), .nfc_cmd_ready(nfc_cmd_ready),
    .nfc_cmd(nfc_cmd), .nfc_cmd_rdata(nfc_cmd_rdata), .nfc_cmd_done(nfc_cmd_done),
    .case_load(case_load), .case_atqa(case_atqa), .case_bad(case_bad), .case_uid(case_uid),
    .case_sak(case_sak), .reqa_frames(reqa_frames), .select_frame(select_frame)
  );

  // Bus protocol watch and start_auth pulse count
  always @(posedge clk) begin
    if (rst_n) begin
      if (nfc_cmd_valid && !nfc_cmd_ready) begin
        $display("nfc_cmd_valid went high while nfc_cmd_ready was low at %0t", $time);
        case_errors = case_errors + 1;
      end
      if (nfc_cmd_valid && valid_prev) begin
        $display("nfc_cmd_valid stayed high for two cycles at %0t", $time);
        case_errors = case_errors + 1;
      end
      if (start_auth) auth_count = auth_count + 1;
    end
    valid_prev = rst_n && nfc_cmd_valid;
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp, act);
    $display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, act);
    case_errors = case_errors + 1;
  endtask

  task automatic check_outputs_clear();
    if (nfc_cmd_valid !== 1'b0) report_mismatch("nfc_cmd_valid", 0, nfc_cmd_valid);
    if (start_auth !== 1'b0) report_mismatch("start_auth", 0, start_auth);
    if (card_ready !== 1'b0) report_mismatch("card_ready", 0, card_ready);
    if (card_detected !== 1'b0) report_mismatch("card_detected", 0, card_detected);
    if (detection_error !== 1'b0) report_mismatch("detection_error", 0, detection_error);
  endtask

  task automatic run_case(input int idx);
    logic [7:0]  bcc;
    logic [7:0]  exp_code;
    logic [55:0] exp_frame;
    logic        card_found;
    logic        exp_ok;
    int          exp_reqa;
    int          cycles;
    case_atqa = case_mem[4*idx][15:0];
    case_bad  = case_mem[4*idx+1][7:0];
    case_uid  = case_mem[4*idx+2];
    case_sak  = case_mem[4*idx+3][7:0];
    card_found = (case_bad < reqa_limit);
    bcc        = case_uid[31:24] ^ case_uid[23:16] ^ case_uid[15:8] ^ case_uid[7:0];
    exp_frame  = card_found ? {8'h93, 8'h70, case_uid, bcc} : 56'h0;   // No SELECT sent
    exp_reqa   = card_found ? case_bad + 1 : reqa_limit;
    exp_code   = !card_found ? 8'hFF : (case_sak[2] ? 8'h01 : 8'h00);
    exp_ok     = card_found && !case_sak[2];
    case_errors = 0;
    auth_count  = 0;
    case_load   = 1'b1;
    @(negedge clk);
    case_load = 1'b0;
    nfc_irq   = 1'b1;
    @(negedge clk);
    nfc_irq = 1'b0;
    cycles  = 0;
    while (!card_ready && !detection_error && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (!card_ready && !detection_error) begin
      $display("case %0d: no start_auth or detection_error after %0d cycles", idx, cycles);
      case_errors = case_errors + 1;
      timed_out   = 1'b1;
    end else begin
      repeat (4) @(negedge clk);   // Room for a stray second pulse
      if (card_ready !== exp_ok) report_mismatch("card_ready", exp_ok, card_ready);
      if (detection_error !== !exp_ok) begin
        report_mismatch("detection_error", !exp_ok, detection_error);
      end
      if (card_detected !== card_found) report_mismatch("card_detected", card_found, card_detected);
      if (auth_count != int'(exp_ok)) report_mismatch("start_auth pulses", exp_ok, auth_count);
      if (reqa_frames != exp_reqa) report_mismatch("REQA frames", exp_reqa, reqa_frames);
      if (exp_ok && card_uid !== case_uid) report_mismatch("card_uid", case_uid, card_uid);
      if (error_code !== exp_code) report_mismatch("error_code", exp_code, error_code);
      if (select_frame !== exp_frame) report_mismatch("SELECT frame", exp_frame, select_frame);
    end
    if (case_errors == 0) passed = passed + 1;
    else failed = failed + 1;
    $display("case %0d: uid %h, %0d bad ATQA, sak %h: %s", idx, case_uid, case_bad, case_sak,
             (case_errors == 0) ? "ok" : "FAIL");
  endtask

  initial begin
    int idx;
    rst_n     = 1'b0;
    nfc_irq   = 1'b0;
    case_load = 1'b0;
    case_atqa = 16'h0000;
    case_bad  = 8'h00;
    case_uid  = 32'h0;
    case_sak  = 8'h00;
    $readmemh("verif/detect_cases.txt", case_mem);
    repeat (2) @(negedge clk);
    check_outputs_clear();
    rst_n = 1'b1;
    @(negedge clk);
    check_outputs_clear();
    if (case_errors == 0) passed = passed + 1;
    else failed = failed + 1;
    $display("reset outputs: %s", (case_errors == 0) ? "ok" : "FAIL");
    idx = 0;
    while (idx < max_cases && !timed_out && !$isunknown(case_mem[4*idx])) begin
      run_case(idx);
      idx = idx + 1;
    end
    $display("tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
    if (failed == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: nfc_card_detector.f
logic/nfc_pkg.sv
logic/nfc_frame_builder.sv
logic/nfc_response_capture.sv
logic/nfc_transceive_seq.sv
logic/nfc_protocol_ctrl.sv
logic/nfc_card_detector.sv
verif/mfrc522_model.sv
verif/tb_nfc_card_detector.sv

// File: Bender.yml
package:
  name: nfc_card_detector

sources:
  - logic/nfc_pkg.sv
  - logic/nfc_frame_builder.sv
  - logic/nfc_response_capture.sv
  - logic/nfc_transceive_seq.sv
  - logic/nfc_protocol_ctrl.sv
  - logic/nfc_card_detector.sv
  - target: simulation
    files:
      - verif/mfrc522_model.sv
      - verif/tb_nfc_card_detector.sv

// File: verif/detect_cases.txt
// atqa  bad_atqa_replies  uid  sak   (hex)
// atqa is sent while bad replies remain, then 0004
0004 0 A1B2C3D4 08
0004 0 12345678 20
0044 3 DEADBEEF 08
0000 4 CAFEF00D 08
0004 0 0BADC0DE 04
0044 1 80FF0102 88
0044 2 5A5A5A5A 0C
0002 5 11223344 08
0004 0 00000000 00
0004 0 FFFFFFFF 18
